/* common/neighbor_defs.svh */
`ifndef NEIGHBOR_DEFS_SVH
`define NEIGHBOR_DEFS_SVH

// graph size and edge pe count
`define NUM_NODES 64
`define NUM_EDGE_PE 4

// two banks, selected by bit 1 of the replay iteration
`define NUM_BANK_NEIGHBOR_INFO 2

// iteration bit 0 picks the half of a bank
`define MAX_REPLAY_ITER 4

// one neighbor word
`define NEIGHBOR_INFO_BANDWIDTH 16

// derived widths
`define NODE_ID_WIDTH $clog2(`NUM_NODES)
`define PE_TAG_WIDTH $clog2(`NUM_EDGE_PE)
`define ITER_WIDTH $clog2(`MAX_REPLAY_ITER)
`define BANK_SEL_WIDTH $clog2(`NUM_BANK_NEIGHBOR_INFO)
// node id plus the iteration half bit
`define BANK_ADDR_WIDTH (`NODE_ID_WIDTH + 1)
`define BANK_WORDS (1 << `BANK_ADDR_WIDTH)

// queue depths
`define REQ_FIFO_DEPTH 8
`define NBR_FIFO_DEPTH 8

`endif

/* common/neighbor_pkg.sv */
`include "neighbor_defs.svh"

package neighbor_pkg;

    // request from an edge pe, as queued
    typedef struct packed {
        logic [`NODE_ID_WIDTH-1:0] node_id;
        logic [`PE_TAG_WIDTH-1:0]  pe_tag;
    } neighbor_req_t;

    // registered head of the request fifo
    typedef struct packed {
        logic          valid;
        neighbor_req_t req;
    } neighbor_req_head_t;

    // per-bank sram control, cen and wen active low
    typedef struct packed {
        logic [`BANK_ADDR_WIDTH-1:0] a;
        logic                        cen;
        logic                        wen;
    } sram_ctrl_t;

    // preload port, only used before traffic starts
    typedef struct packed {
        logic                                valid;
        logic [`BANK_SEL_WIDTH-1:0]          bank;
        logic [`BANK_ADDR_WIDTH-1:0]         addr;
        logic [`NEIGHBOR_INFO_BANDWIDTH-1:0] data;
    } mem_load_t;

    // neighbor word tagged with the requesting pe
    typedef struct packed {
        logic [`NEIGHBOR_INFO_BANDWIDTH-1:0] addr;
        logic [`PE_TAG_WIDTH-1:0]            pe_tag;
    } neighbor_result_t;

    // result with its valid, also the push into the neighbor-id fifo
    typedef struct packed {
        logic             valid;
        neighbor_result_t data;
    } neighbor_result_out_t;

endpackage

/* hdl/neighbor_fetch_top.sv */
`timescale 1ns/10ps
`include "neighbor_defs.svh"

module neighbor_fetch_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req_push,
    input  neighbor_pkg::neighbor_req_t        req_data,
    output logic                               req_full,
    input  logic                               iter_advance,
    input  neighbor_pkg::mem_load_t            mem_load,
    input  logic                               nbr_rinc,
    output neighbor_pkg::neighbor_result_out_t nbr_result,
    output logic                               nbr_empty
);

    import neighbor_pkg::*;

    neighbor_req_head_t         req_head;
    logic                       req_empty;
    logic                       req_rinc;
    logic                       nbr_almost_full;
    logic [`ITER_WIDTH-1:0]     current_replay_iter;
    sram_ctrl_t [`NUM_BANK_NEIGHBOR_INFO-1:0] sram_ctrl;
    logic [`NUM_BANK_NEIGHBOR_INFO-1:0][`NEIGHBOR_INFO_BANDWIDTH-1:0] sram_data;
    neighbor_result_out_t       cntl_result;

    // requests from the edge pes
    sync_fifo #(
        .payload_t (neighbor_req_t),
        .DEPTH     (`REQ_FIFO_DEPTH)
    ) i_req_fifo (
        .clk         (clk),
        .reset       (reset),
        .winc        (req_push),
        .wdata       (req_data),
        .rinc        (req_rinc),
        .rdata       (req_head.req),
        .rvalid      (req_head.valid),
        .empty       (req_empty),
        .full        (req_full),
        .almost_full ()
    );

    neighbor_info_cntl i_cntl (
        .clk                   (clk),
        .reset                 (reset),
        .req_head              (req_head),
        .empty                 (req_empty),
        .current_replay_iter   (current_replay_iter),
        .neighbor_id_fifo_full (nbr_almost_full),
        .data_sram_in          (sram_data),
        .rinc                  (req_rinc),
        .sram_ctrl             (sram_ctrl),
        .result                (cntl_result)
    );

    replay_iter_counter i_iter (
        .clk                 (clk),
        .reset               (reset),
        .iter_advance        (iter_advance),
        .current_replay_iter (current_replay_iter)
    );

    neighbor_info_mem i_mem (
        .clk       (clk),
        .sram_ctrl (sram_ctrl),
        .mem_load  (mem_load),
        .data_out  (sram_data)
    );

    // tagged results toward the consumer
    sync_fifo #(
        .payload_t (neighbor_result_t),
        .DEPTH     (`NBR_FIFO_DEPTH)
    ) i_nbr_fifo (
        .clk         (clk),
        .reset       (reset),
        .winc        (cntl_result.valid),
        .wdata       (cntl_result.data),
        .rinc        (nbr_rinc),
        .rdata       (nbr_result.data),
        .rvalid      (nbr_result.valid),
        .empty       (nbr_empty),
        .full        (),
        .almost_full (nbr_almost_full)
    );

endmodule

/* hdl/neighbor_info_mem.sv */
`timescale 1ns/10ps
`include "neighbor_defs.svh"

module neighbor_info_mem (
    input  logic                                   clk,
    input  neighbor_pkg::sram_ctrl_t [`NUM_BANK_NEIGHBOR_INFO-1:0] sram_ctrl,
    input  neighbor_pkg::mem_load_t                mem_load,
    output logic [`NUM_BANK_NEIGHBOR_INFO-1:0][`NEIGHBOR_INFO_BANDWIDTH-1:0] data_out
);

    // behavioral stand-in for the sram macros, one cycle read latency
    for (genvar b = 0; b < `NUM_BANK_NEIGHBOR_INFO; b++) begin : g_bank
        logic [`NEIGHBOR_INFO_BANDWIDTH-1:0] bank_mem [`BANK_WORDS];
        logic                                load_hit;
        logic                                rd_en;

        assign load_hit = mem_load.valid && (int'(mem_load.bank) == b);
        // read strobe: chip enabled and write disabled
        assign rd_en    = !sram_ctrl[b].cen && sram_ctrl[b].wen;

        always_ff @(posedge clk) begin
            if (load_hit) begin
                bank_mem[mem_load.addr] <= mem_load.data;
            end
            if (rd_en) begin
                data_out[b] <= bank_mem[sram_ctrl[b].a];
            end
        end
    end

endmodule

/* hdl/sync_fifo.sv */
`timescale 1ns/10ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     winc,
    input  payload_t wdata,
    input  logic     rinc,
    output payload_t rdata,
    output logic     rvalid,
    output logic     empty,
    output logic     full,
    output logic     almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_write;
    logic             do_read;

    // wrap at DEPTH, so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // a push while full or a pop while empty is ignored
    assign do_write = winc && !full;
    assign do_read  = rinc && !empty;

    assign empty       = (count == '0);
    assign full        = (count == CNT_W'(DEPTH));
    // leaves room for one result still in flight
    assign almost_full = (count >= CNT_W'(DEPTH - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rvalid <= 1'b0;
        end else begin
            rvalid <= do_read;
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and read register
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
        if (do_read) begin
            rdata <= mem[rd_ptr];
        end
    end

endmodule

/* neighbor_ctrl/neighbor_info_cntl.sv */
`timescale 1ns/10ps
`include "neighbor_defs.svh"

module neighbor_info_cntl (
    input  logic                                   clk,
    input  logic                                   reset,
    input  neighbor_pkg::neighbor_req_head_t       req_head,
    input  logic                                   empty,
    input  logic [`ITER_WIDTH-1:0]                 current_replay_iter,
    input  logic                                   neighbor_id_fifo_full,
    input  logic [`NUM_BANK_NEIGHBOR_INFO-1:0][`NEIGHBOR_INFO_BANDWIDTH-1:0] data_sram_in,
    output logic                                   rinc,
    output neighbor_pkg::sram_ctrl_t [`NUM_BANK_NEIGHBOR_INFO-1:0] sram_ctrl,
    output neighbor_pkg::neighbor_result_out_t     result
);

    import neighbor_pkg::*;

    typedef enum logic {
        IDLE      = 1'b0,
        FETCH_VAL = 1'b1
    } state_t;

    state_t                     state;
    state_t                     nx_state;
    logic [`PE_TAG_WIDTH-1:0]   reg_pe_tag;
    logic [`PE_TAG_WIDTH-1:0]   nx_pe_tag;
    logic [`BANK_SEL_WIDTH-1:0] reg_bank;
    logic [`BANK_SEL_WIDTH-1:0] nx_bank;
    neighbor_result_out_t       nx_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IDLE;
            result.valid <= 1'b0;
        end else begin
            state        <= nx_state;
            result.valid <= nx_result.valid;
        end
    end

    // tag and bank held from strobe to data, result payload
    always_ff @(posedge clk) begin
        reg_pe_tag  <= nx_pe_tag;
        reg_bank    <= nx_bank;
        result.data <= nx_result.data;
    end

    always_comb begin
        nx_state  = state;
        nx_pe_tag = reg_pe_tag;
        nx_bank   = reg_bank;
        rinc      = 1'b0;
        nx_result = '0;
        for (int i = 0; i < `NUM_BANK_NEIGHBOR_INFO; i++) begin
            sram_ctrl[i].a   = '0;
            sram_ctrl[i].cen = 1'b1;
            sram_ctrl[i].wen = 1'b1;
        end

        case (state)
            IDLE: begin
                if (req_head.valid) begin
                    // bank from iteration bit 1, half of the bank from bit 0
                    nx_bank = current_replay_iter[1];
                    sram_ctrl[current_replay_iter[1]].a =
                        {current_replay_iter[0], req_head.req.node_id};
                    sram_ctrl[current_replay_iter[1]].cen = 1'b0;
                    sram_ctrl[current_replay_iter[1]].wen = 1'b1;
                    nx_pe_tag = req_head.req.pe_tag;
                    nx_state  = FETCH_VAL;
                end else if (!empty && !neighbor_id_fifo_full) begin
                    // head shows up next cycle
                    rinc = 1'b1;
                end
            end
            FETCH_VAL: begin
                // sram data is valid one cycle after the strobe
                nx_result.valid       = 1'b1;
                nx_result.data.addr   = data_sram_in[reg_bank];
                nx_result.data.pe_tag = reg_pe_tag;
                nx_state              = IDLE;
            end
            default: nx_state = IDLE;
        endcase
    end

endmodule

/* neighbor_ctrl/replay_iter_counter.sv */
`timescale 1ns/10ps
`include "neighbor_defs.svh"

module replay_iter_counter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   iter_advance,
    output logic [`ITER_WIDTH-1:0] current_replay_iter
);

    logic last_iter;

    // wraps after the final replay iteration
    assign last_iter = (int'(current_replay_iter) == `MAX_REPLAY_ITER - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            current_replay_iter <= '0;
        end else if (iter_advance) begin
            if (last_iter) begin
                current_replay_iter <= '0;
            end else begin
                current_replay_iter <= current_replay_iter + 1'b1;
            end
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the neighbor fetch testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module neighbor_fetch_tb \
    -f tb.f

# assertion failures end the run early, the log decides
./obj_dir/Vneighbor_fetch_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
else
    exit 1
fi

/* tb.f */
+incdir+common
common/neighbor_pkg.sv
hdl/sync_fifo.sv
neighbor_ctrl/replay_iter_counter.sv
neighbor_ctrl/neighbor_info_cntl.sv
hdl/neighbor_info_mem.sv
hdl/neighbor_fetch_top.sv
tb/neighbor_fetch_chk.sv
tb/neighbor_fetch_tb.sv

/* tb/neighbor_fetch_chk.sv */
`timescale 1ns/10ps
`include "neighbor_defs.svh"

module neighbor_fetch_chk (
    input logic                                                 clk,
    input logic                                                 reset,
    input neighbor_pkg::sram_ctrl_t [`NUM_BANK_NEIGHBOR_INFO-1:0] sram_ctrl,
    input logic                                                 rinc,
    input logic                                                 head_valid,
    input logic                                                 result_valid,
    input logic                                                 winc,
    input logic                                                 full
);

    logic [`NUM_BANK_NEIGHBOR_INFO-1:0] strobe;

    always_comb begin
        for (int i = 0; i < `NUM_BANK_NEIGHBOR_INFO; i++) begin
            strobe[i] = !sram_ctrl[i].cen;
        end
    end

    // at most one bank read per cycle
    a_one_bank: assert property (@(posedge clk) disable iff (reset) $onehot0(strobe))
        else $error("more than one bank strobed in a cycle");

    a_rinc_head: assert property (@(posedge clk) disable iff (reset)
        $rose(rinc) |-> !head_valid)
        else $error("rinc rose while the head was valid");

    a_push_full: assert property (@(posedge clk) disable iff (reset) winc |-> !full)
        else $error("push into a full FIFO");

    // strobe, data, then the registered result
    a_result: assert property (@(posedge clk) disable iff (reset)
        (|strobe) |-> ##2 result_valid)
        else $error("no result two cycles after a bank strobe");

endmodule

bind neighbor_info_cntl neighbor_fetch_chk i_cntl_chk (
    .clk          (clk),
    .reset        (reset),
    .sram_ctrl    (sram_ctrl),
    .rinc         (rinc),
    .head_valid   (req_head.valid),
    .result_valid (result.valid),
    .winc         (1'b0),
    .full         (1'b0)
);

bind sync_fifo neighbor_fetch_chk i_fifo_chk (
    .clk          (clk),
    .reset        (reset),
    .sram_ctrl    ('1),
    .rinc         (rinc),
    .head_valid   (rvalid),
    .result_valid (1'b0),
    .winc         (winc),
    .full         (full)
);

/* tb/neighbor_fetch_tb.sv */
`timescale 1ns/10ps
`include "neighbor_defs.svh"

module neighbor_fetch_tb;

    import neighbor_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic                 clk;
    logic                 reset;
    logic                 req_push;
    neighbor_req_t        req_data;
    logic                 req_full;
    logic                 iter_advance;
    mem_load_t            mem_load;
    logic                 nbr_rinc;
    neighbor_result_out_t nbr_result;
    logic                 nbr_empty;

    // copy of what was loaded into the banks
    logic [`NEIGHBOR_INFO_BANDWIDTH-1:0] mirror [`NUM_BANK_NEIGHBOR_INFO][`BANK_WORDS];
    neighbor_result_t       exp_q [$];
    logic [`ITER_WIDTH-1:0] tb_iter;
    int                     seed;
    int                     rnd;
    int                     value_errors;
    int                     other_errors;
    int                     received;
    int                     pushed;
    logic                   saw_full;

    neighbor_fetch_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .req_push     (req_push),
        .req_data     (req_data),
        .req_full     (req_full),
        .iter_advance (iter_advance),
        .mem_load     (mem_load),
        .nbr_rinc     (nbr_rinc),
        .nbr_result   (nbr_result),
        .nbr_empty    (nbr_empty)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // bank from iteration bit 1, address {iteration bit 0, node}
    function automatic neighbor_result_t expected_result(
        input logic [`NODE_ID_WIDTH-1:0] node,
        input logic [`PE_TAG_WIDTH-1:0]  tag,
        input logic [`ITER_WIDTH-1:0]    iter
    );
        neighbor_result_t res;
        res.addr   = mirror[iter[1]][{iter[0], node}];
        res.pe_tag = tag;
        return res;
    endfunction

    task automatic end_test();
        $display("errors: value=%0d other=%0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        other_errors++;
        end_test();
    endtask

    task automatic check_result(input neighbor_result_t got, input neighbor_result_t exp);
        if (got !== exp) begin
            $display("[ERROR] nbr_result.data got addr=%h tag=%h, expected addr=%h tag=%h",
                     got.addr, got.pe_tag, exp.addr, exp.pe_tag);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %s got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic load_memory();
        mem_load_t ld;
        ld       = '0;
        ld.valid = 1'b1;
        for (int b = 0; b < `NUM_BANK_NEIGHBOR_INFO; b++) begin
            for (int a = 0; a < `BANK_WORDS; a++) begin
                rnd           = $random(seed);
                ld.bank       = b[0];
                ld.addr       = a[`BANK_ADDR_WIDTH-1:0];
                ld.data       = rnd[`NEIGHBOR_INFO_BANDWIDTH-1:0];
                mirror[b][a]  = ld.data;
                @(posedge clk);
                mem_load <= ld;
            end
        end
        @(posedge clk);
        mem_load <= '0;
    endtask

    // push is seen by the FIFO on the second edge
    task automatic push_req(input logic [`NODE_ID_WIDTH-1:0] node,
                            input logic [`PE_TAG_WIDTH-1:0]  tag);
        int waited;
        waited = 0;
        @(negedge clk);
        while (req_full && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (req_full) begin
            timed_out("req_full to drop");
        end
        exp_q.push_back(expected_result(node, tag, tb_iter));
        @(posedge clk);
        req_push <= 1'b1;
        req_data <= '{node_id: node, pe_tag: tag};
        @(posedge clk);
        req_push <= 1'b0;
        pushed++;
    endtask

    task automatic push_random();
        rnd = $random(seed);
        push_req(rnd[5:0], rnd[7:6]);
    endtask

    task automatic pop_result();
        int waited;
        waited = 0;
        @(negedge clk);
        while (nbr_empty && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (nbr_empty) begin
            timed_out("nbr_empty to drop");
        end
        @(posedge clk);
        nbr_rinc <= 1'b1;
        @(posedge clk);
        nbr_rinc <= 1'b0;
    endtask

    // pops everything still expected and waits for the compares
    task automatic drain_results();
        int n;
        int waited;
        n      = exp_q.size();
        waited = 0;
        repeat (n) pop_result();
        @(posedge clk);
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (exp_q.size() != 0) begin
            timed_out("outstanding results");
        end
    endtask

    task automatic advance_iter();
        @(posedge clk);
        iter_advance <= 1'b1;
        @(posedge clk);
        iter_advance <= 1'b0;
        tb_iter++;
    endtask

    // every result the DUT hands out is counted
    always @(negedge clk) begin : compare
        neighbor_result_t exp_res;
        if (!reset && nbr_result.valid) begin
            received++;
            if (exp_q.size() == 0) begin
                $display("a result arrived while none was expected");
                other_errors++;
            end else begin
                exp_res = exp_q.pop_front();
                check_result(nbr_result.data, exp_res);
            end
        end
    end

    initial begin
        seed         = 25535;
        value_errors = 0;
        other_errors = 0;
        received     = 0;
        pushed       = 0;
        tb_iter      = '0;
        reset        = 1'b1;
        req_push     = 1'b0;
        req_data     = '0;
        iter_advance = 1'b0;
        mem_load     = '0;
        nbr_rinc     = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // state right after reset
        @(negedge clk);
        check_flag("nbr_empty", nbr_empty, 1'b1);
        check_flag("i_dut.req_empty", i_dut.req_empty, 1'b1);
        check_flag("req_full", req_full, 1'b0);
        check_count("i_dut.current_replay_iter", int'(i_dut.current_replay_iter), 0);
        load_memory();

        // single request, iteration 0
        push_req(6'd5, 2'd2);
        drain_results();

        // iterations 1, 2 and 3
        repeat (3) begin
            advance_iter();
            repeat (2) push_random();
            drain_results();
        end

        // wrap to iteration 0, then a burst
        advance_iter();
        repeat (8) push_random();
        drain_results();

        // nobody reads until the request FIFO fills up
        saw_full = 1'b0;
        while (!saw_full && pushed < 80) begin
            @(negedge clk);
            if (req_full) begin
                saw_full = 1'b1;
            end else begin
                push_random();
            end
        end
        if (!saw_full) begin
            $display("req_full never rose while results were not read");
            other_errors++;
        end
        drain_results();

        check_count("received results", received, pushed);
        end_test();
    end

endmodule
